//--- stream_cfg_pkg.sv
package stream_cfg_pkg;

  // bus widths
  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned DATA_W   = 32;
  localparam int unsigned LEN_W    = 16;
  localparam int unsigned STRIDE_W = 16;

  // reply buffer sizing
  localparam int unsigned BUF_DEPTH = 2;
  localparam int unsigned BUF_PTR_W = $clog2(BUF_DEPTH);
  localparam int unsigned BUF_CNT_W = $clog2(BUF_DEPTH + 1); // holds 0..BUF_DEPTH

  // byte address on the memory port, word aligned
  typedef logic [ADDR_W-1:0] addr_t;

  // one memory or stream word
  typedef logic [DATA_W-1:0] word_t;

  // number of words in a job
  typedef logic [LEN_W-1:0] len_t;

  // unsigned byte step between two words
  typedef logic [STRIDE_W-1:0] stride_t;

endpackage

//--- stream_ctrl_pkg.sv
package stream_ctrl_pkg;

  // only the low address byte selects a register
  localparam int unsigned REG_OFFS_W = 8;

  typedef logic [REG_OFFS_W-1:0] reg_offs_t;

  localparam reg_offs_t REG_CTRL   = 8'h00; // write only, start
  localparam reg_offs_t REG_STATUS = 8'h04;
  localparam reg_offs_t REG_BASE   = 8'h08;
  localparam reg_offs_t REG_STRIDE = 8'h0C;
  localparam reg_offs_t REG_COUNT  = 8'h10;
  localparam reg_offs_t REG_SENT   = 8'h14; // read only

  // bit positions
  localparam int unsigned CTRL_START_BIT  = 0;
  localparam int unsigned STATUS_BUSY_BIT = 0;
  localparam int unsigned STATUS_DONE_BIT = 1;

  // fetch engine states
  typedef enum logic [1:0] {
    SRC_IDLE,
    SRC_ISSUE,
    SRC_DRAIN
  } src_state_e;

endpackage

//--- src_addr_gen.sv
`timescale 1ns/1ns

module src_addr_gen
  import stream_cfg_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    load_i,
  input  addr_t   base_i,
  input  stride_t stride_i,
  input  len_t    count_i,
  input  logic    step_i,
  output addr_t   addr_o,
  output logic    last_o
);

  addr_t addr_q;
  len_t  remain_q; // words not yet granted

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (load_i) begin
      addr_q <= base_i;
    end else if (step_i) begin
      addr_q <= addr_q + addr_t'(stride_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      remain_q <= '0;
    end else if (load_i) begin
      remain_q <= count_i;
    end else if (step_i && remain_q != '0) begin
      remain_q <= remain_q - len_t'(1);
    end
  end

  assign addr_o = addr_q;
  assign last_o = (remain_q <= len_t'(1));

endmodule

//--- src_engine.sv
`timescale 1ns/1ns

module src_engine
  import stream_cfg_pkg::*;
  import stream_ctrl_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    start_i,
  input  addr_t   base_i,
  input  stride_t stride_i,
  input  len_t    count_i,
  input  logic    slot_free_i,
  input  logic    drained_i,
  input  logic    mem_gnt_i,
  output logic    busy_o,
  output logic    done_o,
  output logic    mem_req_o,
  output addr_t   mem_addr_o
);

  src_state_e state_q;
  src_state_e state_d;
  logic       load;
  logic       step;
  logic       last;
  logic       empty_job_q;

  src_addr_gen i_src_addr_gen (
    .clk_i    ( clk_i      ),
    .rst_ni   ( rst_ni     ),
    .load_i   ( load       ),
    .base_i   ( base_i     ),
    .stride_i ( stride_i   ),
    .count_i  ( count_i    ),
    .step_i   ( step       ),
    .addr_o   ( mem_addr_o ),
    .last_o   ( last       )
  );

  assign load = (state_q == SRC_IDLE) & start_i;

  // zero length jobs skip issuing
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      empty_job_q <= 1'b0;
    end else if (load) begin
      empty_job_q <= (count_i == '0);
    end
  end

  always_comb begin
    state_d   = state_q;
    mem_req_o = 1'b0;
    done_o    = 1'b0;
    case (state_q)
      SRC_IDLE: begin
        if (start_i) begin
          state_d = SRC_ISSUE;
        end
      end
      SRC_ISSUE: begin
        if (empty_job_q) begin
          state_d = SRC_DRAIN;
        end else begin
          mem_req_o = slot_free_i; // stays up until granted
          if (mem_req_o && mem_gnt_i && last) begin
            state_d = SRC_DRAIN;
          end
        end
      end
      SRC_DRAIN: begin
        if (drained_i) begin
          state_d = SRC_IDLE;
          done_o  = 1'b1;
        end
      end
      default: state_d = SRC_IDLE;
    endcase
  end

  assign step = mem_req_o & mem_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SRC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign busy_o = (state_q != SRC_IDLE);

endmodule

//--- src_resp_buffer.sv
`timescale 1ns/1ns

module src_resp_buffer
  import stream_cfg_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  start_i,
  input  logic  mem_req_i,
  input  logic  mem_gnt_i,
  input  word_t mem_rdata_i,
  input  logic  mem_rvalid_i,
  input  logic  strm_ready_i,
  output logic  slot_free_o,
  output logic  drained_o,
  output logic  strm_valid_o,
  output word_t strm_data_o,
  output len_t  sent_o
);

  word_t                mem_q [BUF_DEPTH];
  logic [BUF_PTR_W-1:0] wr_ptr_q;
  logic [BUF_PTR_W-1:0] rd_ptr_q;
  logic [BUF_CNT_W-1:0] fill_q;
  logic [BUF_CNT_W-1:0] inflight_q; // granted, reply not yet back
  logic [BUF_CNT_W:0]   occupancy;
  logic                 issue;
  logic                 push;
  logic                 pop;
  len_t                 sent_q;

  function automatic logic [BUF_PTR_W-1:0] next_ptr(input logic [BUF_PTR_W-1:0] ptr);
    if (ptr == BUF_PTR_W'(BUF_DEPTH - 1)) begin
      return '0;
    end
    return ptr + BUF_PTR_W'(1);
  endfunction

  assign issue = mem_req_i & mem_gnt_i;
  assign push  = mem_rvalid_i; // space reserved at grant
  assign pop   = strm_valid_o & strm_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= '0;
    end else if (issue && !push) begin
      inflight_q <= inflight_q + BUF_CNT_W'(1);
    end else if (push && !issue) begin
      inflight_q <= inflight_q - BUF_CNT_W'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      if (push && !pop) begin
        fill_q <= fill_q + BUF_CNT_W'(1);
      end else if (pop && !push) begin
        fill_q <= fill_q - BUF_CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= mem_rdata_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sent_q <= '0;
    end else if (start_i) begin
      sent_q <= '0;
    end else if (pop) begin
      sent_q <= sent_q + len_t'(1);
    end
  end

  assign occupancy    = {1'b0, fill_q} + {1'b0, inflight_q};
  assign slot_free_o  = (occupancy < (BUF_CNT_W + 1)'(BUF_DEPTH));
  assign drained_o    = (fill_q == '0) & (inflight_q == '0);
  assign strm_valid_o = (fill_q != '0);
  assign strm_data_o  = mem_q[rd_ptr_q];
  assign sent_o       = sent_q;

endmodule

//--- apb_src_regs.sv
`timescale 1ns/1ns

module apb_src_regs
  import stream_cfg_pkg::*;
  import stream_ctrl_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    psel_i,
  input  logic    penable_i,
  input  logic    pwrite_i,
  input  addr_t   paddr_i,
  input  word_t   pwdata_i,
  output word_t   prdata_o,
  output logic    pready_o,
  output logic    pslverr_o,
  input  logic    busy_i,
  input  logic    done_i,
  input  len_t    sent_i,
  output logic    start_o,
  output addr_t   base_o,
  output stride_t stride_o,
  output len_t    count_o
);

  reg_offs_t offs;
  logic      upper_zero;
  logic      access;
  logic      mapped;
  logic      job_reg; // registers locked while busy
  logic      wr_ok;
  logic      done_q;
  addr_t     base_q;
  stride_t   stride_q;
  len_t      count_q;

  assign offs       = paddr_i[REG_OFFS_W-1:0];
  assign upper_zero = (paddr_i[ADDR_W-1:REG_OFFS_W] == '0);
  assign access     = psel_i & penable_i;
  assign pready_o   = 1'b1; // no wait states

  always_comb begin
    mapped   = upper_zero;
    job_reg  = 1'b0;
    prdata_o = '0;
    case (offs)
      REG_CTRL: job_reg = 1'b1; // reads as zero
      REG_STATUS: begin
        prdata_o[STATUS_BUSY_BIT] = busy_i;
        prdata_o[STATUS_DONE_BIT] = done_q;
      end
      REG_BASE: begin
        job_reg  = 1'b1;
        prdata_o = base_q;
      end
      REG_STRIDE: begin
        job_reg  = 1'b1;
        prdata_o = word_t'(stride_q);
      end
      REG_COUNT: begin
        job_reg  = 1'b1;
        prdata_o = word_t'(count_q);
      end
      REG_SENT: prdata_o = word_t'(sent_i);
      default:  mapped = 1'b0;
    endcase
  end

  assign pslverr_o = access & (~mapped | (pwrite_i & job_reg & busy_i));
  assign wr_ok     = access & pwrite_i & mapped & ~busy_i;
  assign start_o   = wr_ok & (offs == REG_CTRL) & pwdata_i[CTRL_START_BIT];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q   <= '0;
      stride_q <= '0;
      count_q  <= '0;
    end else if (wr_ok) begin
      case (offs)
        REG_BASE:   base_q   <= pwdata_i;
        REG_STRIDE: stride_q <= pwdata_i[STRIDE_W-1:0];
        REG_COUNT:  count_q  <= pwdata_i[LEN_W-1:0];
        default: ;
      endcase
    end
  end

  // sticky until the next job starts
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else if (start_o) begin
      done_q <= 1'b0;
    end else if (done_i) begin
      done_q <= 1'b1;
    end
  end

  assign base_o   = base_q;
  assign stride_o = stride_q;
  assign count_o  = count_q;

endmodule

//--- stream_source_top.sv
`timescale 1ns/1ns

module stream_source_top
  import stream_cfg_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  // apb slave
  input  logic  psel_i,
  input  logic  penable_i,
  input  logic  pwrite_i,
  input  addr_t paddr_i,
  input  word_t pwdata_i,
  output word_t prdata_o,
  output logic  pready_o,
  output logic  pslverr_o,
  // memory port
  output logic  mem_req_o,
  output addr_t mem_addr_o,
  input  logic  mem_gnt_i,
  input  word_t mem_rdata_i,
  input  logic  mem_rvalid_i,
  // stream out
  output logic  strm_valid_o,
  output word_t strm_data_o,
  input  logic  strm_ready_i
);

  logic    start;
  logic    busy;
  logic    done;
  logic    slot_free;
  logic    drained;
  addr_t   base;
  stride_t stride;
  len_t    count;
  len_t    sent;

  apb_src_regs i_apb_src_regs (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .psel_i    ( psel_i    ),
    .penable_i ( penable_i ),
    .pwrite_i  ( pwrite_i  ),
    .paddr_i   ( paddr_i   ),
    .pwdata_i  ( pwdata_i  ),
    .prdata_o  ( prdata_o  ),
    .pready_o  ( pready_o  ),
    .pslverr_o ( pslverr_o ),
    .busy_i    ( busy      ),
    .done_i    ( done      ),
    .sent_i    ( sent      ),
    .start_o   ( start     ),
    .base_o    ( base      ),
    .stride_o  ( stride    ),
    .count_o   ( count     )
  );

  src_engine i_src_engine (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .start_i     ( start      ),
    .base_i      ( base       ),
    .stride_i    ( stride     ),
    .count_i     ( count      ),
    .slot_free_i ( slot_free  ),
    .drained_i   ( drained    ),
    .mem_gnt_i   ( mem_gnt_i  ),
    .busy_o      ( busy       ),
    .done_o      ( done       ),
    .mem_req_o   ( mem_req_o  ),
    .mem_addr_o  ( mem_addr_o )
  );

  src_resp_buffer i_src_resp_buffer (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .start_i      ( start        ),
    .mem_req_i    ( mem_req_o    ),
    .mem_gnt_i    ( mem_gnt_i    ),
    .mem_rdata_i  ( mem_rdata_i  ),
    .mem_rvalid_i ( mem_rvalid_i ),
    .strm_ready_i ( strm_ready_i ),
    .slot_free_o  ( slot_free    ),
    .drained_o    ( drained      ),
    .strm_valid_o ( strm_valid_o ),
    .strm_data_o  ( strm_data_o  ),
    .sent_o       ( sent         )
  );

endmodule

//--- tb_stream_source_sva.sv
`timescale 1ns/1ns

module tb_stream_source_sva
  import stream_cfg_pkg::*;
(
  input logic  clk_i,
  input logic  rst_ni,
  input logic  mem_req_i,
  input addr_t mem_addr_i,
  input logic  mem_gnt_i,
  input logic  strm_valid_i,
  input word_t strm_data_i,
  input logic  strm_ready_i,
  input logic  busy_i // low only in SRC_IDLE
);

  // request and address held until the grant
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i && !mem_gnt_i |=> mem_req_i && $stable(mem_addr_i))
    else $error("mem_req_o dropped or mem_addr_o changed before grant");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    strm_valid_i && !strm_ready_i |=> strm_valid_i && $stable(strm_data_i))
    else $error("stream beat changed while stalled");

  // idle engine has no request out and nothing left to stream
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !busy_i |-> !mem_req_i && !strm_valid_i)
    else $error("memory request or stream beat while engine idle");

endmodule

bind stream_source_top tb_stream_source_sva i_tb_stream_source_sva (
  .clk_i        ( clk_i        ),
  .rst_ni       ( rst_ni       ),
  .mem_req_i    ( mem_req_o    ),
  .mem_addr_i   ( mem_addr_o   ),
  .mem_gnt_i    ( mem_gnt_i    ),
  .strm_valid_i ( strm_valid_o ),
  .strm_data_i  ( strm_data_o  ),
  .strm_ready_i ( strm_ready_i ),
  .busy_i       ( busy         )
);

//--- tb_stream_source.sv
`timescale 1ns/1ns

module tb_stream_source
  import stream_cfg_pkg::*;
  import stream_ctrl_pkg::*;
();

  localparam int unsigned SEED            = 32'h6e64;
  localparam int unsigned TOTAL_WORDS     = 8 + 40 + 16 + 0 + 10 + 12;
  localparam int unsigned WATCHDOG_CYCLES = TOTAL_WORDS * 40 + 2000;

  logic    clk_i = 1'b0;
  logic    rst_ni;
  logic    psel;
  logic    penable;
  logic    pwrite;
  addr_t   paddr;
  word_t   pwdata;
  word_t   prdata;
  logic    pready;
  logic    pslverr;
  logic    mem_req;
  addr_t   mem_addr;
  logic    mem_gnt;
  word_t   mem_rdata;
  logic    mem_rvalid;
  logic    strm_valid;
  word_t   strm_data;
  logic    strm_ready;
  logic    rand_gnt; // else grant every cycle
  logic    rand_rdy;
  addr_t   exp_base;
  stride_t exp_stride;
  len_t    exp_count;
  int      beat_idx;
  int      req_cycles;
  int      checks;
  int      errors;
  int      tests;
  int      test_err0;

  always #4 clk_i = ~clk_i;

  stream_source_top i_stream_source_top (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .psel_i       ( psel       ),
    .penable_i    ( penable    ),
    .pwrite_i     ( pwrite     ),
    .paddr_i      ( paddr      ),
    .pwdata_i     ( pwdata     ),
    .prdata_o     ( prdata     ),
    .pready_o     ( pready     ),
    .pslverr_o    ( pslverr    ),
    .mem_req_o    ( mem_req    ),
    .mem_addr_o   ( mem_addr   ),
    .mem_gnt_i    ( mem_gnt    ),
    .mem_rdata_i  ( mem_rdata  ),
    .mem_rvalid_i ( mem_rvalid ),
    .strm_valid_o ( strm_valid ),
    .strm_data_o  ( strm_data  ),
    .strm_ready_i ( strm_ready )
  );

  // memory content, every address bit matters
  function automatic word_t mem_word(input addr_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a3c_0f96;
  endfunction

  // word k of a job: pattern at base + k * stride
  function automatic word_t expected_word(input addr_t base, input stride_t stride, input int k);
    return mem_word(base + addr_t'(k) * addr_t'(stride));
  endfunction

  task automatic check_eq(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s got 0x%h expected 0x%h", what, got, exp);
    end
  endtask

  // memory model and stream sink
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      mem_gnt    <= 1'b0;
      mem_rvalid <= 1'b0;
      strm_ready <= 1'b0;
    end else begin
      mem_gnt    <= rand_gnt ? (($urandom % 2) != 0) : 1'b1;
      mem_rvalid <= mem_req & mem_gnt; // reply one cycle after grant
      if (mem_req && mem_gnt) mem_rdata <= mem_word(mem_addr);
      if (mem_req) req_cycles <= req_cycles + 1;
      strm_ready <= rand_rdy ? (($urandom % 2) != 0) : 1'b1;
    end
  end

  // compare each stream beat with the reference
  always @(posedge clk_i) begin
    if (rst_ni && strm_valid && strm_ready) begin
      if (beat_idx >= int'(exp_count)) begin
        errors++;
        $display("Error: stream beat %0d arrived after the last word of the job", beat_idx);
      end else begin
        check_eq($sformatf("strm_data_o beat %0d", beat_idx), strm_data,
                 expected_word(exp_base, exp_stride, beat_idx));
      end
      beat_idx++;
    end
  end

  task automatic apb_write(input addr_t addr, input word_t data, output logic err);
    @(posedge clk_i);
    psel    <= 1'b1;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk_i);
    penable <= 1'b1;
    @(posedge clk_i);
    err = pslverr; // access phase value
    check_eq("pready_o", word_t'(pready), 32'h1);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input addr_t addr, output word_t data, output logic err);
    @(posedge clk_i);
    psel    <= 1'b1;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk_i);
    penable <= 1'b1;
    @(posedge clk_i);
    data = prdata;
    err  = pslverr;
    check_eq("pready_o", word_t'(pready), 32'h1);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic start_job(input addr_t base, input stride_t stride, input len_t count);
    logic err;
    exp_base   = base;
    exp_stride = stride;
    exp_count  = count;
    beat_idx   = 0;
    apb_write(addr_t'(REG_BASE), base, err);
    check_eq("pslverr_o (BASE write)", word_t'(err), 32'h0);
    apb_write(addr_t'(REG_STRIDE), word_t'(stride), err);
    check_eq("pslverr_o (STRIDE write)", word_t'(err), 32'h0);
    apb_write(addr_t'(REG_COUNT), word_t'(count), err);
    check_eq("pslverr_o (COUNT write)", word_t'(err), 32'h0);
    apb_write(addr_t'(REG_CTRL), 32'h1, err);
    check_eq("pslverr_o (CTRL start)", word_t'(err), 32'h0);
  endtask

  // poll STATUS until done, the watchdog bounds it
  task automatic finish_job();
    word_t rd;
    logic  err;
    rd = '0;
    while (rd[STATUS_DONE_BIT] == 1'b0) begin
      apb_read(addr_t'(REG_STATUS), rd, err);
    end
    check_eq("strm_valid_o handshakes", word_t'(beat_idx), word_t'(exp_count));
    apb_read(addr_t'(REG_SENT), rd, err);
    check_eq("prdata_o (SENT)", rd, word_t'(exp_count));
    apb_read(addr_t'(REG_STATUS), rd, err);
    check_eq("prdata_o (STATUS after job)", rd, 32'h2);
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_err0) $display("test %0d %s: ok", tests, name);
    else $display("test %0d %s: %0d errors", tests, name, errors - test_err0);
    test_err0 = errors;
  endtask

  initial begin
    word_t rd;
    logic  err;
    int    req_before;
    rst_ni     = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    mem_gnt    = 1'b0;
    mem_rdata  = '0;
    mem_rvalid = 1'b0;
    strm_ready = 1'b0;
    rand_gnt   = 1'b0;
    rand_rdy   = 1'b0;
    exp_base   = '0;
    exp_stride = '0;
    exp_count  = '0;
    beat_idx   = 0;
    req_cycles = 0;
    checks     = 0;
    errors     = 0;
    tests      = 0;
    test_err0  = 0;
    void'($urandom(SEED));
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    apb_read(addr_t'(REG_SENT), rd, err);
    check_eq("prdata_o (SENT after reset)", rd, 32'h0);
    apb_read(addr_t'(REG_STATUS), rd, err);
    check_eq("prdata_o (STATUS after reset)", rd, 32'h0);
    apb_write(addr_t'(REG_BASE), 32'h8765_4320, err);
    apb_write(addr_t'(REG_STRIDE), 32'h0000_0abc, err);
    apb_write(addr_t'(REG_COUNT), 32'h0000_0033, err);
    apb_read(addr_t'(REG_BASE), rd, err);
    check_eq("prdata_o (BASE)", rd, 32'h8765_4320);
    apb_read(addr_t'(REG_STRIDE), rd, err);
    check_eq("prdata_o (STRIDE)", rd, 32'h0000_0abc);
    apb_read(addr_t'(REG_COUNT), rd, err);
    check_eq("prdata_o (COUNT)", rd, 32'h0000_0033);
    end_test("register access");

    start_job(32'h0000_0100, 16'd4, 16'd8);
    finish_job();
    end_test("fixed job, no stalls");

    rand_gnt = 1'b1;
    rand_rdy = 1'b1;
    start_job(32'h2000_0040, 16'd12, 16'd40);
    finish_job();
    end_test("random grant and ready");

    apb_write(addr_t'(8'h18), 32'h1, err);
    check_eq("pslverr_o (write 0x18)", word_t'(err), 32'h1);
    apb_write(32'h0000_0108, 32'h1, err);
    check_eq("pslverr_o (write 0x108)", word_t'(err), 32'h1);
    start_job(32'h0000_3000, 16'd8, 16'd16);
    apb_write(addr_t'(REG_BASE), 32'hdead_0000, err); // job still running
    check_eq("pslverr_o (BASE write while busy)", word_t'(err), 32'h1);
    finish_job();
    apb_read(addr_t'(REG_BASE), rd, err);
    check_eq("prdata_o (BASE after busy write)", rd, 32'h0000_3000);
    end_test("bus errors");

    req_before = req_cycles;
    start_job(32'h0000_4000, 16'd4, 16'd0);
    finish_job();
    check_eq("mem_req_o cycles", word_t'(req_cycles), word_t'(req_before));
    end_test("zero count");

    start_job(32'h0001_0000, 16'h40, 16'd10);
    finish_job();
    start_job(32'h0002_0004, 16'h104, 16'd12);
    apb_read(addr_t'(REG_SENT), rd, err);
    check_eq("prdata_o (SENT after restart)", rd, 32'h0);
    apb_read(addr_t'(REG_STATUS), rd, err);
    check_eq("prdata_o (STATUS after restart)", rd, 32'h1);
    finish_job();
    end_test("back to back jobs");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, a job never finished", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- sim.f
stream_cfg_pkg.sv
stream_ctrl_pkg.sv
src_addr_gen.sv
src_engine.sv
src_resp_buffer.sv
apb_src_regs.sv
stream_source_top.sv
tb_stream_source_sva.sv
tb_stream_source.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_stream_source
if ./obj_dir/Vtb_stream_source > sim.log 2>&1; then
  status=0
else
  status=1
fi
cat sim.log
if [ "$status" -ne 0 ] || grep -q "SIMULATION FAILED" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
exit 0
